//--- logic/husky_reg_pkg.sv
package husky_reg_pkg;

   // Host bus address and data width
   localparam int BUS_W = 8;

   // Register map seen by the host
   typedef enum logic [BUS_W-1:0] {
      REG_TARGET_CTRL = 8'h10,
      REG_LA_ARM      = 8'h20, // Bit0 arms, read gives capture state
      REG_LA_DIV      = 8'h21, // Sample every div+1 cycles
      REG_LA_COUNT    = 8'h22, // Samples per capture
      REG_FIFO_STATUS = 8'h30, // Rd: empty/full/overflow, wr: bit0 clear, bit7 flush
      REG_FIFO_READ   = 8'h31  // Stream address, one pop per read
   } reg_addr_e;

   // Bits of REG_TARGET_CTRL
   localparam int TGT_PWR_OFF_BIT  = 0;
   localparam int TGT_AVRPROG_BIT  = 1;
   localparam int TGT_NRST_OE_BIT  = 2;
   localparam int TGT_NRST_VAL_BIT = 3;

endpackage

//--- logic/husky_capture_pkg.sv
package husky_capture_pkg;

   // Capture FIFO geometry
   localparam int FIFO_DEPTH = 64;
   localparam int FIFO_AW    = 6;

   // One sample of the user IO pins
   typedef logic [7:0] fifo_word_t;

   // Logic analyzer state machine
   typedef enum logic [1:0] {
      LA_IDLE    = 2'd0,
      LA_ARMED   = 2'd1,
      LA_CAPTURE = 2'd2,
      LA_DONE    = 2'd3
   } la_state_e;

   // Error LED toggles once per counter wrap
   localparam int FLASH_BITS = 4;

endpackage

//--- logic/usb_reg_bridge.sv
`timescale 1ns/1ps

module usb_reg_bridge (
   input  logic                              clk_usb_buf,
   input  logic                              rst_i,
   input  logic [husky_reg_pkg::BUS_W-1:0]   usb_addr_i,
   input  logic [husky_reg_pkg::BUS_W-1:0]   usb_data_i,
   input  logic                              usb_rdn_i,
   input  logic                              usb_wrn_i,
   input  logic                              usb_cen_i,
   input  logic [husky_reg_pkg::BUS_W-1:0]   tgt_rdata_i,
   input  logic [husky_reg_pkg::BUS_W-1:0]   la_rdata_i,
   input  logic [husky_reg_pkg::BUS_W-1:0]   fifo_rdata_i,
   input  husky_capture_pkg::fifo_word_t     fifo_head_i,
   output logic [husky_reg_pkg::BUS_W-1:0]   reg_addr_o,
   output logic [husky_reg_pkg::BUS_W-1:0]   reg_wdata_o,
   output logic                              reg_read_o,
   output logic                              reg_write_o,
   output logic                              fifo_pop_o,
   output logic [husky_reg_pkg::BUS_W-1:0]   usb_data_o
);

   logic                            wr_s1, wr_s2;
   logic                            rd_s1, rd_s2;
   logic                            stream_sel;
   logic [husky_reg_pkg::BUS_W-1:0] addr_q;
   logic [husky_reg_pkg::BUS_W-1:0] wdata_q;
   logic [husky_reg_pkg::BUS_W-1:0] rdata_q;

   // Strobe sampling and edge detection
   always_ff @(posedge clk_usb_buf) begin
      if (rst_i) begin
         wr_s1       <= 1'b0;
         wr_s2       <= 1'b0;
         rd_s1       <= 1'b0;
         rd_s2       <= 1'b0;
         reg_write_o <= 1'b0;
         reg_read_o  <= 1'b0;
         fifo_pop_o  <= 1'b0;
      end else begin
         wr_s1       <= ~usb_cen_i & ~usb_wrn_i;
         wr_s2       <= wr_s1;
         rd_s1       <= ~usb_cen_i & ~usb_rdn_i;
         rd_s2       <= rd_s1;
         reg_write_o <= wr_s1 & ~wr_s2; // Single pulse per host write
         reg_read_o  <= rd_s1 & ~rd_s2;
         fifo_pop_o  <= ~rd_s1 & rd_s2 & stream_sel; // Pop once the read ends
      end
   end

   // Address and data held from the last active strobe
   always_ff @(posedge clk_usb_buf) begin
      if (!usb_cen_i && !(usb_rdn_i && usb_wrn_i)) begin
         addr_q  <= usb_addr_i;
         wdata_q <= usb_data_i;
      end
   end

   // Unselected blocks return zero, so a plain OR merges them
   always_ff @(posedge clk_usb_buf) begin
      rdata_q <= tgt_rdata_i | la_rdata_i | fifo_rdata_i;
   end

   assign stream_sel  = (addr_q == husky_reg_pkg::REG_FIFO_READ);
   assign reg_addr_o  = addr_q;
   assign reg_wdata_o = wdata_q;
   assign usb_data_o  = stream_sel ? fifo_head_i : rdata_q; // Stream bypasses the merge

endmodule

//--- logic/target_io_ctrl.sv
`timescale 1ns/1ps

module target_io_ctrl (
   input  logic                              clk_usb_buf,
   input  logic                              rst_i,
   input  logic [husky_reg_pkg::BUS_W-1:0]   reg_addr_i,
   input  logic [husky_reg_pkg::BUS_W-1:0]   reg_wdata_i,
   input  logic                              reg_write_i,
   input  logic                              sam_mosi_i,
   input  logic                              sam_spck_i,
   input  logic                              target_miso_i,
   output logic [husky_reg_pkg::BUS_W-1:0]   rdata_o,
   output logic                              target_poweron_o,
   output logic                              target_nrst_o,
   output logic                              target_nrst_oe_o,
   output logic                              target_mosi_o,
   output logic                              target_mosi_oe_o,
   output logic                              target_sck_o,
   output logic                              target_sck_oe_o,
   output logic                              sam_miso_o,
   output logic                              sam_miso_oe_o
);

   logic [husky_reg_pkg::BUS_W-1:0] ctrl_q;
   logic                            sel;
   logic                            pwr_off;
   logic                            avrprog;

   assign sel = (reg_addr_i == husky_reg_pkg::REG_TARGET_CTRL);

   always_ff @(posedge clk_usb_buf) begin
      if (rst_i) begin
         ctrl_q <= '0;
         ctrl_q[husky_reg_pkg::TGT_PWR_OFF_BIT] <= 1'b1; // Target starts unpowered
      end else if (reg_write_i && sel) begin
         ctrl_q <= reg_wdata_i;
      end
   end

   assign rdata_o = sel ? ctrl_q : '0;
   assign pwr_off = ctrl_q[husky_reg_pkg::TGT_PWR_OFF_BIT];
   assign avrprog = ctrl_q[husky_reg_pkg::TGT_AVRPROG_BIT];

   // Priority is power off, then AVR programming, then plain nRST
   assign target_poweron_o = ~pwr_off;
   assign target_mosi_o    = sam_mosi_i;
   assign target_mosi_oe_o = ~pwr_off & avrprog;
   assign target_sck_o     = sam_spck_i;
   assign target_sck_oe_o  = ~pwr_off & avrprog;
   assign target_nrst_o    = avrprog ? sam_spck_i : ctrl_q[husky_reg_pkg::TGT_NRST_VAL_BIT];
   assign target_nrst_oe_o = ~pwr_off & (avrprog | ctrl_q[husky_reg_pkg::TGT_NRST_OE_BIT]);

   // MISO back to the SAM follows programming mode only
   assign sam_miso_o    = target_miso_i;
   assign sam_miso_oe_o = avrprog;

endmodule

//--- logic/la_capture.sv
`timescale 1ns/1ps

module la_capture (
   input  logic                              clk_usb_buf,
   input  logic                              rst_i,
   input  logic [husky_reg_pkg::BUS_W-1:0]   reg_addr_i,
   input  logic [husky_reg_pkg::BUS_W-1:0]   reg_wdata_i,
   input  logic                              reg_write_i,
   input  husky_capture_pkg::fifo_word_t     userio_d_i,
   input  logic                              trig_i,
   output logic [husky_reg_pkg::BUS_W-1:0]   rdata_o,
   output logic                              wr_o,
   output husky_capture_pkg::fifo_word_t     wr_data_o,
   output logic                              led_armed_o,
   output logic                              led_cap_o
);

   husky_capture_pkg::la_state_e            state_q;
   logic [husky_reg_pkg::BUS_W-1:0]         div_q;
   logic [husky_reg_pkg::BUS_W-1:0]         div_cnt_q;
   logic [husky_capture_pkg::FIFO_AW:0]     count_q;
   logic [husky_capture_pkg::FIFO_AW:0]     taken_q;
   logic [husky_capture_pkg::FIFO_AW:0]     taken_nxt;
   logic                                    trig_q;
   logic                                    trig_rise;
   logic                                    arm_wr;
   logic                                    sample;

   assign trig_rise = trig_i & ~trig_q;
   assign arm_wr    = reg_write_i && (reg_addr_i == husky_reg_pkg::REG_LA_ARM);
   assign taken_nxt = taken_q + 1'b1;
   assign sample    = !arm_wr &&
                      ((state_q == husky_capture_pkg::LA_ARMED && trig_rise) ||
                       (state_q == husky_capture_pkg::LA_CAPTURE && div_cnt_q == '0));

   always_ff @(posedge clk_usb_buf) begin
      if (rst_i) begin
         state_q   <= husky_capture_pkg::LA_IDLE;
         div_q     <= '0;
         div_cnt_q <= '0;
         count_q   <= {{husky_capture_pkg::FIFO_AW{1'b0}}, 1'b1};
         taken_q   <= '0;
         trig_q    <= 1'b0;
         wr_o      <= 1'b0;
      end else begin
         trig_q <= trig_i;
         wr_o   <= sample;
         if (reg_write_i && reg_addr_i == husky_reg_pkg::REG_LA_DIV) div_q <= reg_wdata_i;
         // Count clamped to 1..FIFO_DEPTH
         if (reg_write_i && reg_addr_i == husky_reg_pkg::REG_LA_COUNT) begin
            if (reg_wdata_i[husky_reg_pkg::BUS_W-1:husky_capture_pkg::FIFO_AW] != '0)
               count_q <= {1'b1, {husky_capture_pkg::FIFO_AW{1'b0}}};
            else if (reg_wdata_i == '0)
               count_q <= {{husky_capture_pkg::FIFO_AW{1'b0}}, 1'b1};
            else
               count_q <= reg_wdata_i[husky_capture_pkg::FIFO_AW:0];
         end
         if (arm_wr) begin
            state_q <= reg_wdata_i[0] ? husky_capture_pkg::LA_ARMED : husky_capture_pkg::LA_IDLE;
            taken_q <= '0;
         end else if (sample) begin
            taken_q   <= taken_nxt;
            div_cnt_q <= div_q; // Restart the pacing window
            state_q   <= (taken_nxt == count_q) ? husky_capture_pkg::LA_DONE
                                                : husky_capture_pkg::LA_CAPTURE;
         end else if (state_q == husky_capture_pkg::LA_CAPTURE) begin
            div_cnt_q <= div_cnt_q - 1'b1;
         end
      end
   end

   always_ff @(posedge clk_usb_buf) begin
      if (sample) wr_data_o <= userio_d_i;
   end

   always_comb begin
      rdata_o = '0;
      case (reg_addr_i)
         husky_reg_pkg::REG_LA_ARM:   rdata_o = {6'b0, state_q};
         husky_reg_pkg::REG_LA_DIV:   rdata_o = div_q;
         husky_reg_pkg::REG_LA_COUNT: rdata_o = {1'b0, count_q};
         default:                     rdata_o = '0;
      endcase
   end

   assign led_armed_o = (state_q == husky_capture_pkg::LA_ARMED);
   assign led_cap_o   = (state_q == husky_capture_pkg::LA_CAPTURE);

endmodule

//--- logic/capture_fifo.sv
`timescale 1ns/1ps

module capture_fifo (
   input  logic                              clk_usb_buf,
   input  logic                              rst_i,
   input  logic [husky_reg_pkg::BUS_W-1:0]   reg_addr_i,
   input  logic [husky_reg_pkg::BUS_W-1:0]   reg_wdata_i,
   input  logic                              reg_write_i,
   input  logic                              wr_i,
   input  husky_capture_pkg::fifo_word_t     wr_data_i,
   input  logic                              pop_i,
   output husky_capture_pkg::fifo_word_t     head_o,
   output logic [husky_reg_pkg::BUS_W-1:0]   rdata_o,
   output logic                              error_o
);

   husky_capture_pkg::fifo_word_t       mem [husky_capture_pkg::FIFO_DEPTH];
   logic [husky_capture_pkg::FIFO_AW:0] wr_ptr_q; // Extra bit tells full from empty
   logic [husky_capture_pkg::FIFO_AW:0] rd_ptr_q;
   logic                                empty;
   logic                                full;
   logic                                overflow_q;
   logic                                stat_sel;
   logic                                flush;
   logic                                clear_err;
   logic                                do_wr;
   logic                                do_pop;

   assign empty = (wr_ptr_q == rd_ptr_q);
   assign full  = (wr_ptr_q[husky_capture_pkg::FIFO_AW] != rd_ptr_q[husky_capture_pkg::FIFO_AW])
               && (wr_ptr_q[husky_capture_pkg::FIFO_AW-1:0]
                   == rd_ptr_q[husky_capture_pkg::FIFO_AW-1:0]);

   assign stat_sel  = (reg_addr_i == husky_reg_pkg::REG_FIFO_STATUS);
   assign flush     = reg_write_i & stat_sel & reg_wdata_i[7];
   assign clear_err = reg_write_i & stat_sel & reg_wdata_i[0];
   assign do_wr     = wr_i & ~full;  // Full FIFO drops the word
   assign do_pop    = pop_i & ~empty;

   always_ff @(posedge clk_usb_buf) begin
      if (rst_i || flush) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
      end else begin
         if (do_wr) wr_ptr_q <= wr_ptr_q + 1'b1;
         if (do_pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      end
   end

   // Sticky until cleared by the host
   always_ff @(posedge clk_usb_buf) begin
      if (rst_i) begin
         overflow_q <= 1'b0;
      end else if (clear_err) begin
         overflow_q <= 1'b0;
      end else if (wr_i && full) begin
         overflow_q <= 1'b1;
      end
   end

   always_ff @(posedge clk_usb_buf) begin
      if (do_wr) mem[wr_ptr_q[husky_capture_pkg::FIFO_AW-1:0]] <= wr_data_i;
   end

   assign head_o  = mem[rd_ptr_q[husky_capture_pkg::FIFO_AW-1:0]];
   assign rdata_o = stat_sel ? {5'b0, overflow_q, full, empty} : '0;
   assign error_o = overflow_q;

endmodule

//--- logic/status_leds.sv
`timescale 1ns/1ps

module status_leds (
   input  logic clk_usb_buf,
   input  logic rst_i,
   input  logic fifo_error_i,
   output logic led_err_o
);

   logic [husky_capture_pkg::FLASH_BITS-1:0] flash_cnt_q;
   logic                                     flash_q;
   logic                                     error_any;

   // Only the capture FIFO reports errors now
   assign error_any = fifo_error_i;

   always_ff @(posedge clk_usb_buf) begin
      if (rst_i) begin
         flash_cnt_q <= '0;
         flash_q     <= 1'b0;
      end else begin
         flash_cnt_q <= flash_cnt_q + 1'b1;
         if (&flash_cnt_q) flash_q <= ~flash_q; // Toggle on wrap
      end
   end

   assign led_err_o = error_any & flash_q;

endmodule

//--- logic/husky_top.sv
`timescale 1ns/1ps

module husky_top (
   input  logic                              clk_usb_buf,
   input  logic                              rst_i,
   input  logic [husky_reg_pkg::BUS_W-1:0]   usb_addr_i,
   input  logic [husky_reg_pkg::BUS_W-1:0]   usb_data_i,
   input  logic                              usb_rdn_i,
   input  logic                              usb_wrn_i,
   input  logic                              usb_cen_i,
   input  husky_capture_pkg::fifo_word_t     userio_d_i,
   input  logic                              trig_i,
   input  logic                              sam_mosi_i,
   input  logic                              sam_spck_i,
   input  logic                              target_miso_i,
   output logic [husky_reg_pkg::BUS_W-1:0]   usb_data_o,
   output logic                              led_armed_o,
   output logic                              led_cap_o,
   output logic                              led_err_o,
   output logic                              target_poweron_o,
   output logic                              target_nrst_o,
   output logic                              target_nrst_oe_o,
   output logic                              target_mosi_o,
   output logic                              target_mosi_oe_o,
   output logic                              target_sck_o,
   output logic                              target_sck_oe_o,
   output logic                              sam_miso_o,
   output logic                              sam_miso_oe_o
);

   logic [husky_reg_pkg::BUS_W-1:0] reg_addr;
   logic [husky_reg_pkg::BUS_W-1:0] reg_wdata;
   logic                            reg_write;
   logic [husky_reg_pkg::BUS_W-1:0] tgt_rdata;
   logic [husky_reg_pkg::BUS_W-1:0] la_rdata;
   logic [husky_reg_pkg::BUS_W-1:0] fifo_rdata;
   husky_capture_pkg::fifo_word_t   fifo_head;
   husky_capture_pkg::fifo_word_t   la_wr_data;
   logic                            fifo_pop;
   logic                            la_wr;
   logic                            fifo_error;

   usb_reg_bridge u_bridge (
      .clk_usb_buf   (clk_usb_buf),
      .rst_i         (rst_i),
      .usb_addr_i    (usb_addr_i),
      .usb_data_i    (usb_data_i),
      .usb_rdn_i     (usb_rdn_i),
      .usb_wrn_i     (usb_wrn_i),
      .usb_cen_i     (usb_cen_i),
      .tgt_rdata_i   (tgt_rdata),
      .la_rdata_i    (la_rdata),
      .fifo_rdata_i  (fifo_rdata),
      .fifo_head_i   (fifo_head),
      .reg_addr_o    (reg_addr),
      .reg_wdata_o   (reg_wdata),
      .reg_read_o    (),           // Blocks decode reads from the address alone
      .reg_write_o   (reg_write),
      .fifo_pop_o    (fifo_pop),
      .usb_data_o    (usb_data_o)
   );

   target_io_ctrl u_tgt (
      .clk_usb_buf      (clk_usb_buf),
      .rst_i            (rst_i),
      .reg_addr_i       (reg_addr),
      .reg_wdata_i      (reg_wdata),
      .reg_write_i      (reg_write),
      .sam_mosi_i       (sam_mosi_i),
      .sam_spck_i       (sam_spck_i),
      .target_miso_i    (target_miso_i),
      .rdata_o          (tgt_rdata),
      .target_poweron_o (target_poweron_o),
      .target_nrst_o    (target_nrst_o),
      .target_nrst_oe_o (target_nrst_oe_o),
      .target_mosi_o    (target_mosi_o),
      .target_mosi_oe_o (target_mosi_oe_o),
      .target_sck_o     (target_sck_o),
      .target_sck_oe_o  (target_sck_oe_o),
      .sam_miso_o       (sam_miso_o),
      .sam_miso_oe_o    (sam_miso_oe_o)
   );

   la_capture u_la (
      .clk_usb_buf  (clk_usb_buf),
      .rst_i        (rst_i),
      .reg_addr_i   (reg_addr),
      .reg_wdata_i  (reg_wdata),
      .reg_write_i  (reg_write),
      .userio_d_i   (userio_d_i),
      .trig_i       (trig_i),
      .rdata_o      (la_rdata),
      .wr_o         (la_wr),
      .wr_data_o    (la_wr_data),
      .led_armed_o  (led_armed_o),
      .led_cap_o    (led_cap_o)
   );

   // Single writer, so no source select in front of the FIFO
   capture_fifo u_fifo (
      .clk_usb_buf  (clk_usb_buf),
      .rst_i        (rst_i),
      .reg_addr_i   (reg_addr),
      .reg_wdata_i  (reg_wdata),
      .reg_write_i  (reg_write),
      .wr_i         (la_wr),
      .wr_data_i    (la_wr_data),
      .pop_i        (fifo_pop),
      .head_o       (fifo_head),
      .rdata_o      (fifo_rdata),
      .error_o      (fifo_error)
   );

   status_leds u_leds (
      .clk_usb_buf  (clk_usb_buf),
      .rst_i        (rst_i),
      .fifo_error_i (fifo_error),
      .led_err_o    (led_err_o)
   );

endmodule

//--- verif/tb_husky_top.sv
`timescale 1ns/1ps

module tb_husky_top;

   logic                            clk_usb_buf;
   logic                            rst_i;
   logic [husky_reg_pkg::BUS_W-1:0] usb_addr_i, usb_data_i, usb_data_o;
   logic                            usb_rdn_i, usb_wrn_i, usb_cen_i;
   husky_capture_pkg::fifo_word_t   userio_d_i;
   logic                            trig_i, sam_mosi_i, sam_spck_i, target_miso_i;
   logic                            led_armed_o, led_cap_o, led_err_o;
   logic                            target_poweron_o, target_nrst_o, target_nrst_oe_o;
   logic                            target_mosi_o, target_mosi_oe_o, target_sck_o;
   logic                            target_sck_oe_o, sam_miso_o, sam_miso_oe_o;

   logic [31:0]                     vectors [64];
   husky_capture_pkg::fifo_word_t   model_q [$];   // Words the FIFO should hold
   logic [31:0]                     lfsr_q;
   int                              num_vec;
   int                              errors;
   int                              checks;
   int                              cycles = 0;
   int                              cycle_limit = 0;

   husky_top dut (.*);

   initial begin
      clk_usb_buf = 1'b0;
      forever #2 clk_usb_buf = ~clk_usb_buf;
   end

   always @(posedge clk_usb_buf) begin
      cycles <= cycles + 1;
      if (cycle_limit > 0 && cycles >= cycle_limit) begin
         $display("Timeout: run did not finish within %0d cycles", cycle_limit);
         $display("Test failures found");
         $finish;
      end
   end

   task automatic check_byte(input logic [husky_reg_pkg::BUS_W-1:0] got,
                             input logic [husky_reg_pkg::BUS_W-1:0] exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED at time %0t: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_word(input husky_capture_pkg::fifo_word_t got,
                             input husky_capture_pkg::fifo_word_t exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED at time %0t: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_bit(input logic got, input logic exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED at time %0t: %s got %b expected %b", $time, what, got, exp);
      end
   endtask

   // Galois LFSR stepped once per sample bit
   function automatic husky_capture_pkg::fifo_word_t next_sample();
      husky_capture_pkg::fifo_word_t v;
      v = '0;
      for (int b = 0; b < 8; b++) begin
         v      = {v[6:0], lfsr_q[0]};
         lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h80200003) : (lfsr_q >> 1);
      end
      return v;
   endfunction

   task automatic bus_write(input logic [7:0] addr, input logic [7:0] data);
      usb_addr_i <= addr;
      usb_data_i <= data;
      usb_cen_i  <= 1'b0;
      usb_wrn_i  <= 1'b0;
      repeat (4) @(posedge clk_usb_buf);
      usb_cen_i <= 1'b1;
      usb_wrn_i <= 1'b1;
      repeat (3) @(posedge clk_usb_buf);
   endtask

   task automatic bus_read(input logic [7:0] addr, output logic [7:0] data);
      usb_addr_i <= addr;
      usb_cen_i  <= 1'b0;
      usb_rdn_i  <= 1'b0;
      repeat (4) @(posedge clk_usb_buf);
      @(negedge clk_usb_buf);
      data = usb_data_o;
      @(posedge clk_usb_buf);
      usb_cen_i <= 1'b1;
      usb_rdn_i <= 1'b1;
      repeat (3) @(posedge clk_usb_buf); // Stream pop lands two cycles after release
   endtask

   // Drive bits 0..2 are SAM MOSI, SAM SPCK and target MISO
   task automatic check_pins(input logic [7:0] drive, input logic [7:0] exp);
      sam_mosi_i    <= drive[0];
      sam_spck_i    <= drive[1];
      target_miso_i <= drive[2];
      @(negedge clk_usb_buf);
      check_bit(target_poweron_o, exp[7], "target_poweron_o");
      check_bit(target_nrst_oe_o, exp[6], "target_nrst_oe_o");
      check_bit(target_nrst_o, exp[5], "target_nrst_o");
      check_bit(target_mosi_oe_o, exp[4], "target_mosi_oe_o");
      check_bit(target_sck_oe_o, exp[3], "target_sck_oe_o");
      check_bit(sam_miso_oe_o, exp[2], "sam_miso_oe_o");
      check_bit(target_mosi_o, exp[1], "target_mosi_o");
      check_bit(sam_miso_o, exp[0], "sam_miso_o");
      check_bit(target_sck_o, drive[1], "target_sck_o");
      @(posedge clk_usb_buf);
   endtask

   task automatic run_capture(input logic [7:0] div, input logic [7:0] cnt,
                              input logic [7:0] exp);
      logic [7:0]                    rd;
      husky_capture_pkg::fifo_word_t smp;
      int                            n;
      int                            polls;
      n = (cnt == 0) ? 1 : ((cnt > 64) ? 64 : int'(cnt));
      bus_write(husky_reg_pkg::REG_LA_DIV, div);
      bus_write(husky_reg_pkg::REG_LA_COUNT, cnt);
      bus_write(husky_reg_pkg::REG_LA_ARM, 8'h01);
      bus_read(husky_reg_pkg::REG_LA_ARM, rd);
      check_byte(rd, {6'b0, husky_capture_pkg::LA_ARMED}, "LA state after arm");
      @(negedge clk_usb_buf);
      check_bit(led_armed_o, 1'b1, "led_armed_o while armed");
      @(posedge clk_usb_buf);
      // One new pin value per sample window
      for (int k = 0; k < n; k++) begin
         smp = next_sample();
         userio_d_i <= smp;
         trig_i     <= 1'b1;   // Rises together with the first pin value
         if (model_q.size() < husky_capture_pkg::FIFO_DEPTH)
            model_q.push_back(smp);   // Full FIFO drops the word
         if (k == 0 && n > 1) begin
            @(posedge clk_usb_buf);
            @(negedge clk_usb_buf);
            check_bit(led_cap_o, 1'b1, "led_cap_o while capturing");
            repeat (int'(div)) @(posedge clk_usb_buf);
         end else begin
            repeat (int'(div) + 1) @(posedge clk_usb_buf);
         end
      end
      trig_i <= 1'b0;
      rd    = 8'h00;
      polls = 0;
      while (rd != exp && polls < 8) begin
         bus_read(husky_reg_pkg::REG_LA_ARM, rd);
         polls++;
      end
      check_byte(rd, exp, "LA state after capture");
   endtask

   task automatic stream_read(input int n);
      logic [7:0] got;
      for (int k = 0; k < n; k++) begin
         bus_read(husky_reg_pkg::REG_FIFO_READ, got);
         if (model_q.size() == 0) begin
            errors++;
            $display("Stream read %0d returned a word although none was expected", k);
         end else begin
            check_word(got, model_q.pop_front(), "stream word");
         end
      end
   endtask

   task automatic watch_led(input logic exp_flash);
      logic saw_high;
      logic saw_low;
      saw_high = 1'b0;
      saw_low  = 1'b0;
      repeat (40) begin
         @(negedge clk_usb_buf);
         if (led_err_o)
            saw_high = 1'b1;
         else
            saw_low = 1'b1;
      end
      check_bit(saw_high, exp_flash, "led_err_o lit within 40 cycles");
      if (exp_flash)
         check_bit(saw_low, 1'b1, "led_err_o dark within 40 cycles");
      @(posedge clk_usb_buf);
   endtask

   initial begin
      logic [7:0] op, addr, data, exp, rd;
      int         bad_before;
      rst_i         = 1'b1;
      usb_addr_i    = '0;
      usb_data_i    = '0;
      usb_rdn_i     = 1'b1;
      usb_wrn_i     = 1'b1;
      usb_cen_i     = 1'b1;
      userio_d_i    = '0;
      trig_i        = 1'b0;
      sam_mosi_i    = 1'b0;
      sam_spck_i    = 1'b0;
      target_miso_i = 1'b0;
      errors        = 0;
      checks        = 0;
      num_vec       = 0;
      lfsr_q        = 32'h80289c12;
      $readmemh("verif/husky_input.txt", vectors);
      while (num_vec < 64 && !$isunknown(vectors[num_vec]) && vectors[num_vec][31:24] != 8'h00)
         num_vec++;
      if (num_vec == 0) begin
         errors++;
         $display("No test vectors were found in verif/husky_input.txt");
      end
      cycle_limit = num_vec * 200;
      repeat (10) @(posedge clk_usb_buf);
      rst_i <= 1'b0;
      @(posedge clk_usb_buf);
      for (int i = 0; i < num_vec; i++) begin
         op         = vectors[i][31:24];
         addr       = vectors[i][23:16];
         data       = vectors[i][15:8];
         exp        = vectors[i][7:0];
         bad_before = errors;
         case (op)
            8'h01: begin
               bus_write(addr, data);
               if (addr == husky_reg_pkg::REG_FIFO_STATUS && data[7])
                  model_q.delete();   // Flush empties the FIFO
            end
            8'h02: begin
               bus_read(addr, rd);
               check_byte(rd, exp, $sformatf("read of register %h", addr));
            end
            8'h03: check_pins(addr, exp);
            8'h04: run_capture(addr, data, exp);
            8'h05: stream_read(int'(data));
            8'h06: watch_led(data[0]);
            default: begin
               errors++;
               $display("Vector %0d has an unknown operation code %h", i, op);
            end
         endcase
         $display("Test %0d (op %h addr %h): %s", i, op, addr,
                  (errors == bad_before) ? "ok" : "FAILED");
      end
      $display("%0d tests run, %0d checks, %0d errors", num_vec, checks, errors);
      if (errors == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

//--- verif/husky_input.txt
// One 32-bit word per line: op, addr, data, expected (8 bits each)
// Ops 01 write, 02 read, 03 pins (addr = SAM drive), 04 capture (addr = div, data = count)
// Ops 05 stream read (data = words), 06 error LED (data 1 = flashing), 00 end
03000000
02100001
02300001
02200000
01100400
030000c0
01100c00
030000e0
01100200
030700ff
030100de
01100300
03000004
02100003
04020503
05000500
02300001
04004003
04000803
02300006
06000100
01308100
02300001
06000000
00000000

//--- tb.f
logic/husky_reg_pkg.sv
logic/husky_capture_pkg.sv
logic/usb_reg_bridge.sv
logic/target_io_ctrl.sv
logic/la_capture.sv
logic/capture_fifo.sv
logic/status_leds.sv
logic/husky_top.sv
verif/tb_husky_top.sv

//--- Makefile
SIM      = verilator
VFLAGS   = --binary --timing
TOP      = tb_husky_top
FILELIST = tb.f
OBJDIR   = obj_dir
BIN      = $(OBJDIR)/V$(TOP)
LOG      = sim.log
SRCS     = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "Test failures found" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "All tests passed!" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)
